//--- sources.f
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/rv_decoder.sv
logic/rv_exec_unit.sv
logic/rv_pc_unit.sv
logic/rv_writeback.sv
logic/rv_top.sv
tests/rv_top_assertions.sv
tests/tb_rv_top.sv

//--- tests/tb_rv_top.sv
`default_nettype none

module tb_rv_top;
    timeunit 1ns;
    timeprecision 1ps;

    logic        CLK;
    logic        RSTn;
    logic        I_MEM_CSN;
    logic [31:0] I_MEM_DI;
    logic [11:0] I_MEM_ADDR;
    logic        D_MEM_CSN;
    logic [31:0] D_MEM_DI;
    logic [31:0] D_MEM_DOUT;
    logic [11:0] D_MEM_ADDR;
    logic        D_MEM_WEN;
    logic [3:0]  D_MEM_BE;
    logic        RF_WE;
    logic [4:0]  RF_RA1;
    logic [4:0]  RF_RA2;
    logic [4:0]  RF_WA1;
    logic [31:0] RF_RD1;
    logic [31:0] RF_RD2;
    logic [31:0] RF_WD;
    logic        HALT;
    logic [31:0] NUM_INST;

    logic [31:0] imem [0:1023];
    logic [31:0] dmem [0:4095];
    logic [31:0] regs [0:31];
    logic [31:0] prog [$];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          seed = 32'h6254_6e58;

    rv_top #(
        .IMEM_ADDR_W (12),
        .DMEM_ADDR_W (12)
    ) u_rv_top (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial RSTn = 1'b0;

    // Memories and register file read combinationally
    assign I_MEM_DI = imem[I_MEM_ADDR[11:2]];
    assign D_MEM_DI = dmem[D_MEM_ADDR];
    assign RF_RD1   = (RF_RA1 == 5'd0) ? 32'd0 : regs[RF_RA1];
    assign RF_RD2   = (RF_RA2 == 5'd0) ? 32'd0 : regs[RF_RA2];

    always @(posedge CLK) begin
        if (RF_WE && RF_WA1 != 5'd0) regs[RF_WA1] <= RF_WD;
        if (!D_MEM_CSN && !D_MEM_WEN) begin
            if (D_MEM_BE[0]) dmem[D_MEM_ADDR][7:0]   <= D_MEM_DOUT[7:0];
            if (D_MEM_BE[1]) dmem[D_MEM_ADDR][15:8]  <= D_MEM_DOUT[15:8];
            if (D_MEM_BE[2]) dmem[D_MEM_ADDR][23:16] <= D_MEM_DOUT[23:16];
            if (D_MEM_BE[3]) dmem[D_MEM_ADDR][31:24] <= D_MEM_DOUT[31:24];
        end
    end

    initial begin
        #(6 * 200 * 10);
        $display("Watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Each word built from its own address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0] ^ 16'h5a3c, ~a[15:0]};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input int r, input logic [31:0] exp);
        check($sformatf("x%0d", r), regs[r], exp);
    endtask

    // Loads the queued program plus the halt sequence while the core sits in reset
    task automatic enter_reset();
        @(posedge CLK);
        RSTn <= 1'b0;
        @(posedge CLK);
        prog.push_back(enc_i(12'd12, 5'd0, 3'b000, 5'd1, rv_isa_pkg::OP_IMM));
        prog.push_back(rv_isa_pkg::HALT_INST);
        for (int i = 0; i < 1024; i++) imem[i] = (i < prog.size()) ? prog[i] : 32'd0;
        for (int i = 0; i < 4096; i++) dmem[i] = fill_word(i);
        for (int i = 0; i < 32; i++) regs[i] = 32'd0;
        prog.delete();
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        check("I_MEM_CSN", I_MEM_CSN, 1'b1);
        check("D_MEM_CSN", D_MEM_CSN, 1'b1);
        check("RF_WE", RF_WE, 1'b0);
        check("I_MEM_ADDR", I_MEM_ADDR, 12'd0);
        check("NUM_INST", NUM_INST, 32'd0);
    endtask

    task automatic run_to_halt();
        bit halted;
        halted = 1'b0;
        @(posedge CLK);
        RSTn <= 1'b1;
        for (int cyc = 0; cyc < 150 && !halted; cyc++) begin
            @(negedge CLK);
            halted = (HALT === 1'b1);
        end
        checks++;
        assert (halted) else begin
            $display("Error at %0t: program never reached the halt word", $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("%s test: %s", name, (errors == err_before) ? "ok" : "errors");
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        enter_reset();
        run_to_halt();
        finish_test("reset", e0);
    endtask

    task automatic test_arith();
        int e0;
        logic [31:0] a;
        logic [31:0] b;
        e0 = errors;
        a = $random(seed);
        b = $random(seed);
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd4));
        prog.push_back(enc_r(7'h20, 5'd3, 5'd2, 3'd0, 5'd5));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'd1, 5'd6));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd7));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd8));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'd4, 5'd9));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'd5, 5'd10));
        prog.push_back(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd11));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'd6, 5'd12));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'd7, 5'd13));
        prog.push_back(enc_i(12'hffb, 5'd2, 3'd0, 5'd14, rv_isa_pkg::OP_IMM));
        prog.push_back(enc_i(12'h123, 5'd2, 3'd4, 5'd15, rv_isa_pkg::OP_IMM));
        prog.push_back(enc_i(12'h007, 5'd2, 3'd2, 5'd16, rv_isa_pkg::OP_IMM));
        prog.push_back(enc_i(12'h407, 5'd2, 3'd5, 5'd17, rv_isa_pkg::OP_IMM)); // srai 7
        prog.push_back(enc_i(12'h0f0, 5'd2, 3'd7, 5'd18, rv_isa_pkg::OP_IMM));
        enter_reset();
        regs[2] = a;
        regs[3] = b;
        run_to_halt();
        check_reg(4, a + b);
        check_reg(5, a - b);
        check_reg(6, a << b[4:0]);
        check_reg(7, {31'd0, $signed(a) < $signed(b)});
        check_reg(8, {31'd0, a < b});
        check_reg(9, a ^ b);
        check_reg(10, a >> b[4:0]);
        check_reg(11, $signed(a) >>> b[4:0]);
        check_reg(12, a | b);
        check_reg(13, a & b);
        check_reg(14, a - 32'd5);
        check_reg(15, a ^ 32'h123);
        check_reg(16, {31'd0, $signed(a) < 7});
        check_reg(17, $signed(a) >>> 7);
        check_reg(18, a & 32'h0f0);
        finish_test("arithmetic", e0);
    endtask

    task automatic test_branch();
        int e0;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3 [6];
        bit          taken [6];
        e0 = errors;
        a = 32'hffff_fff0; // Negative signed yet large unsigned
        b = 32'd5;
        f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        taken = '{a == b, a != b, $signed(a) < $signed(b), $signed(a) >= $signed(b),
                  a < b, a >= b};
        for (int k = 0; k < 6; k++) begin
            prog.push_back(enc_b(13'd12, 5'd3, 5'd2, f3[k]));
            prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'(10 + k), rv_isa_pkg::OP_IMM));
            prog.push_back(enc_j(21'd8, 5'd0));
            prog.push_back(enc_i(12'd2, 5'd0, 3'd0, 5'(10 + k), rv_isa_pkg::OP_IMM));
        end
        prog.push_back(enc_b(13'd8, 5'd3, 5'd3, 3'b000)); // Equal operands
        prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd16, rv_isa_pkg::OP_IMM));
        prog.push_back(enc_i(12'd2, 5'd0, 3'd0, 5'd17, rv_isa_pkg::OP_IMM));
        enter_reset();
        regs[2] = a;
        regs[3] = b;
        run_to_halt();
        for (int k = 0; k < 6; k++) check_reg(10 + k, taken[k] ? 32'd2 : 32'd1);
        check_reg(16, 32'd0);
        check_reg(17, 32'd2);
        finish_test("branch", e0);
    endtask

    task automatic test_memory();
        int e0;
        logic [31:0] d;
        logic [31:0] fill_41;
        logic [31:0] fill_42;
        e0 = errors;
        d = $random(seed) | 32'h0000_8080; // Byte and half both negative
        fill_41 = fill_word(32'h41);
        fill_42 = fill_word(32'h42);
        prog.push_back(enc_s(12'd0, 5'd3, 5'd2, 3'b010));
        prog.push_back(enc_i(12'd0, 5'd2, 3'b010, 5'd4, rv_isa_pkg::LOAD));
        prog.push_back(enc_s(12'd4, 5'd3, 5'd2, 3'b000));
        prog.push_back(enc_i(12'd4, 5'd2, 3'b000, 5'd5, rv_isa_pkg::LOAD));
        prog.push_back(enc_i(12'd4, 5'd2, 3'b100, 5'd6, rv_isa_pkg::LOAD));
        prog.push_back(enc_s(12'd8, 5'd3, 5'd2, 3'b001));
        prog.push_back(enc_i(12'd8, 5'd2, 3'b001, 5'd7, rv_isa_pkg::LOAD));
        prog.push_back(enc_i(12'd8, 5'd2, 3'b101, 5'd8, rv_isa_pkg::LOAD));
        enter_reset();
        regs[2] = 32'h100;
        regs[3] = d;
        run_to_halt();
        check("dmem[0x40]", dmem['h40], d);
        check("dmem[0x41]", dmem['h41], {fill_41[31:8], d[7:0]});
        check("dmem[0x42]", dmem['h42], {fill_42[31:16], d[15:0]});
        check_reg(4, d);
        check_reg(5, {{24{d[7]}}, d[7:0]});
        check_reg(6, {24'd0, d[7:0]});
        check_reg(7, {{16{d[15]}}, d[15:0]});
        check_reg(8, {16'd0, d[15:0]});
        finish_test("memory", e0);
    endtask

    task automatic test_jump();
        int e0;
        e0 = errors;
        prog.push_back(enc_j(21'd8, 5'd5));                                     // pc 0
        prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd6, rv_isa_pkg::OP_IMM));     // Skipped
        prog.push_back({20'h12345, 5'd7, 7'b0110111});                          // lui
        prog.push_back({20'h00001, 5'd8, 7'b0010111});                          // pc 12 auipc
        prog.push_back(enc_i(12'd29, 5'd0, 3'd0, 5'd2, rv_isa_pkg::OP_IMM));
        prog.push_back(enc_i(12'd0, 5'd2, 3'd0, 5'd9, rv_isa_pkg::JALR));       // pc 20
        prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd10, rv_isa_pkg::OP_IMM));    // Skipped
        prog.push_back({20'h00000, 5'd11, 7'b0010111});                         // pc 28 auipc
        enter_reset();
        run_to_halt();
        check_reg(5, 32'd4);
        check_reg(6, 32'd0);
        check_reg(7, 32'h1234_5000);
        check_reg(8, 32'd12 + 32'h1000);
        check_reg(9, 32'd24);
        check_reg(10, 32'd0);
        check_reg(11, 32'd28); // Odd target 29 lands on 28
        finish_test("jump", e0);
    endtask

    task automatic test_halt();
        int e0;
        e0 = errors;
        prog.push_back(enc_i(12'd7, 5'd0, 3'd0, 5'd2, rv_isa_pkg::OP_IMM));
        prog.push_back(enc_i(12'd9, 5'd0, 3'd0, 5'd3, rv_isa_pkg::OP_IMM));
        enter_reset();
        run_to_halt(); // Halt word sits at 12 and jumps to itself
        check("NUM_INST", NUM_INST, 32'd3);
        repeat (5) @(negedge CLK);
        check("HALT", HALT, 1'b1);
        check("NUM_INST", NUM_INST, 32'd3);
        finish_test("halt", e0);
    endtask

    initial begin
        test_reset();
        test_arith();
        test_branch();
        test_memory();
        test_jump();
        test_halt();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/rv_top_assertions.sv
`default_nettype none

module rv_top_assertions (
    input  logic        CLK,
    input  logic        RSTn,
    input  logic        I_MEM_CSN,
    input  logic        D_MEM_CSN,
    input  logic        D_MEM_WEN,
    input  logic        RF_WE,
    input  logic        HALT,
    input  logic [31:0] I_MEM_DI
);
    timeunit 1ns;
    timeprecision 1ps;

    // Strobes idle in reset
    a_reset_idle: assert property (@(posedge CLK) !RSTn |-> I_MEM_CSN && D_MEM_CSN && !RF_WE)
        else $error("Strobe active during reset");

    a_wen_needs_cs: assert property (@(posedge CLK) !D_MEM_WEN |-> !D_MEM_CSN)
        else $error("Data write enable without chip select");

    a_halt_word: assert property (@(posedge CLK) HALT |-> I_MEM_DI == rv_isa_pkg::HALT_INST)
        else $error("HALT raised on another instruction");

endmodule

bind rv_top rv_top_assertions u_assertions (
    .CLK       (CLK),
    .RSTn      (RSTn),
    .I_MEM_CSN (I_MEM_CSN),
    .D_MEM_CSN (D_MEM_CSN),
    .D_MEM_WEN (D_MEM_WEN),
    .RF_WE     (RF_WE),
    .HALT      (HALT),
    .I_MEM_DI  (I_MEM_DI)
);

`default_nettype wire

//--- logic/rv_top.sv
`default_nettype none

module rv_top #(
    parameter int IMEM_ADDR_W = 12,
    parameter int DMEM_ADDR_W = 12
) (
    input  logic                        CLK,
    input  logic                        RSTn,
    output logic                        I_MEM_CSN,
    input  logic [rv_isa_pkg::XLEN-1:0] I_MEM_DI,
    output logic [IMEM_ADDR_W-1:0]      I_MEM_ADDR,  // Byte address
    output logic                        D_MEM_CSN,
    input  logic [rv_isa_pkg::XLEN-1:0] D_MEM_DI,
    output logic [rv_isa_pkg::XLEN-1:0] D_MEM_DOUT,
    output logic [DMEM_ADDR_W-1:0]      D_MEM_ADDR,  // Word address
    output logic                        D_MEM_WEN,
    output logic [3:0]                  D_MEM_BE,
    output logic                        RF_WE,
    output logic [4:0]                  RF_RA1,
    output logic [4:0]                  RF_RA2,
    output logic [4:0]                  RF_WA1,
    input  logic [rv_isa_pkg::XLEN-1:0] RF_RD1,
    input  logic [rv_isa_pkg::XLEN-1:0] RF_RD2,
    output logic [rv_isa_pkg::XLEN-1:0] RF_WD,
    output logic                        HALT,
    output logic [rv_isa_pkg::XLEN-1:0] NUM_INST
);

    logic [rv_isa_pkg::XLEN-1:0] imm;
    rv_ctrl_pkg::alu_op_e        alu_op;
    logic                        b_is_imm;
    rv_ctrl_pkg::wd_sel_e        wd_sel;
    rv_ctrl_pkg::mem_size_e      load_size;
    logic                        load_unsigned;
    logic                        branch;
    logic                        jump;
    logic                        jalr;
    logic                        halt_inst;
    logic [rv_isa_pkg::XLEN-1:0] alu_result;
    logic                        bcond;
    logic [rv_isa_pkg::XLEN-1:0] pc_plus4;
    logic [rv_isa_pkg::XLEN-1:0] pc_imm;

    // Low two address bits dropped
    assign D_MEM_ADDR = alu_result[DMEM_ADDR_W+1:2];
    assign D_MEM_DOUT = RF_RD2;

    rv_decoder u_decoder (
        .RSTn          (RSTn),
        .inst          (I_MEM_DI),
        .I_MEM_CSN     (I_MEM_CSN),
        .D_MEM_CSN     (D_MEM_CSN),
        .D_MEM_WEN     (D_MEM_WEN),
        .D_MEM_BE      (D_MEM_BE),
        .RF_WE         (RF_WE),
        .rs1_addr      (RF_RA1),
        .rs2_addr      (RF_RA2),
        .rd_addr       (RF_WA1),
        .imm           (imm),
        .alu_op        (alu_op),
        .b_is_imm      (b_is_imm),
        .wd_sel        (wd_sel),
        .load_size     (load_size),
        .load_unsigned (load_unsigned),
        .branch        (branch),
        .jump          (jump),
        .jalr          (jalr),
        .halt_inst     (halt_inst)
    );

    rv_exec_unit u_exec (
        .rs1      (RF_RD1),
        .rs2      (RF_RD2),
        .imm      (imm),
        .b_is_imm (b_is_imm),
        .alu_op   (alu_op),
        .result   (alu_result),
        .bcond    (bcond)
    );

    rv_pc_unit #(
        .IMEM_ADDR_W (IMEM_ADDR_W)
    ) u_pc (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .rs1        (RF_RD1),
        .imm        (imm),
        .branch     (branch),
        .jump       (jump),
        .jalr       (jalr),
        .bcond      (bcond),
        .halt_inst  (halt_inst),
        .I_MEM_ADDR (I_MEM_ADDR),
        .pc_plus4   (pc_plus4),
        .pc_imm     (pc_imm),
        .HALT       (HALT),
        .NUM_INST   (NUM_INST)
    );

    rv_writeback u_writeback (
        .wd_sel        (wd_sel),
        .alu_result    (alu_result),
        .mem_data      (D_MEM_DI),
        .load_size     (load_size),
        .load_unsigned (load_unsigned),
        .imm           (imm),
        .pc_plus4      (pc_plus4),
        .pc_imm        (pc_imm),
        .wd            (RF_WD)
    );

endmodule

`default_nettype wire

//--- logic/rv_writeback.sv
`default_nettype none

module rv_writeback (
    input  rv_ctrl_pkg::wd_sel_e        wd_sel,
    input  logic [rv_isa_pkg::XLEN-1:0] alu_result,
    input  logic [rv_isa_pkg::XLEN-1:0] mem_data,
    input  rv_ctrl_pkg::mem_size_e      load_size,
    input  logic                        load_unsigned,
    input  logic [rv_isa_pkg::XLEN-1:0] imm,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_plus4,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_imm,
    output logic [rv_isa_pkg::XLEN-1:0] wd
);

    logic [rv_isa_pkg::XLEN-1:0] load_data;
    logic                        byte_fill;
    logic                        half_fill;

    // Sign bit, or zero for LBU and LHU
    assign byte_fill = mem_data[7] && !load_unsigned;
    assign half_fill = mem_data[15] && !load_unsigned;

    always_comb begin
        case (load_size)
            rv_ctrl_pkg::MEM_BYTE: load_data = {{(rv_isa_pkg::XLEN-8){byte_fill}}, mem_data[7:0]};
            rv_ctrl_pkg::MEM_HALF: load_data = {{(rv_isa_pkg::XLEN-16){half_fill}},
                                                mem_data[15:0]};
            rv_ctrl_pkg::MEM_WORD: load_data = mem_data;
            default:               load_data = mem_data;
        endcase
    end

    always_comb begin
        case (wd_sel)
            rv_ctrl_pkg::WD_ALU:    wd = alu_result;
            rv_ctrl_pkg::WD_MEM:    wd = load_data;
            rv_ctrl_pkg::WD_PC4:    wd = pc_plus4;   // JAL, JALR link
            rv_ctrl_pkg::WD_IMM:    wd = imm;
            rv_ctrl_pkg::WD_PC_IMM: wd = pc_imm;
            default:                wd = alu_result;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_pc_unit.sv
`default_nettype none

module rv_pc_unit #(
    parameter int IMEM_ADDR_W = 12
) (
    input  logic                        CLK,
    input  logic                        RSTn,
    input  logic [rv_isa_pkg::XLEN-1:0] rs1,
    input  logic [rv_isa_pkg::XLEN-1:0] imm,
    input  logic                        branch,
    input  logic                        jump,
    input  logic                        jalr,
    input  logic                        bcond,
    input  logic                        halt_inst,
    output logic [IMEM_ADDR_W-1:0]      I_MEM_ADDR,
    output logic [rv_isa_pkg::XLEN-1:0] pc_plus4,
    output logic [rv_isa_pkg::XLEN-1:0] pc_imm,
    output logic                        HALT,
    output logic [rv_isa_pkg::XLEN-1:0] NUM_INST
);

    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic [rv_isa_pkg::XLEN-1:0] jalr_sum;
    logic [rv_isa_pkg::XLEN-1:0] target;
    logic [rv_isa_pkg::XLEN-1:0] next_pc;
    logic                        take;

    assign pc_plus4 = pc + rv_isa_pkg::XLEN'(4);
    assign pc_imm   = pc + imm;  // Branch, JAL and AUIPC
    assign jalr_sum = rs1 + imm;

    // JALR drops bit 0 of its target
    assign target = jalr ? {jalr_sum[rv_isa_pkg::XLEN-1:1], 1'b0} : pc_imm;

    assign take    = jump || (branch && bcond);
    assign next_pc = take ? target : pc_plus4;

    assign I_MEM_ADDR = pc[IMEM_ADDR_W-1:0];

    assign HALT = halt_inst && (rs1 == rv_isa_pkg::HALT_RS1_VALUE);

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    // One instruction per cycle, frozen once halted
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            NUM_INST <= '0;
        end else if (!HALT) begin
            NUM_INST <= NUM_INST + rv_isa_pkg::XLEN'(1);
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_exec_unit.sv
`default_nettype none

module rv_exec_unit (
    input  logic [rv_isa_pkg::XLEN-1:0] rs1,
    input  logic [rv_isa_pkg::XLEN-1:0] rs2,
    input  logic [rv_isa_pkg::XLEN-1:0] imm,
    input  logic                        b_is_imm,
    input  rv_ctrl_pkg::alu_op_e        alu_op,
    output logic [rv_isa_pkg::XLEN-1:0] result,
    output logic                        bcond
);

    logic [rv_isa_pkg::XLEN-1:0] op_b;
    logic [4:0]                  shamt;
    logic                        lt_s;
    logic                        lt_u;

    assign op_b  = b_is_imm ? imm : rs2;
    assign shamt = op_b[4:0]; // Only the low five bits shift
    assign lt_s  = $signed(rs1) < $signed(op_b);
    assign lt_u  = rs1 < op_b;

    always_comb begin
        result = '0; // Stays zero for compares
        bcond  = 1'b0;
        case (alu_op)
            rv_ctrl_pkg::ALU_ADD:  result = rs1 + op_b;
            rv_ctrl_pkg::ALU_SUB:  result = rs1 - op_b;
            rv_ctrl_pkg::ALU_SLT:  result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_s};
            rv_ctrl_pkg::ALU_SLTU: result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_u};
            rv_ctrl_pkg::ALU_SLL:  result = rs1 << shamt;
            rv_ctrl_pkg::ALU_SRL:  result = rs1 >> shamt;
            rv_ctrl_pkg::ALU_SRA:  result = $unsigned($signed(rs1) >>> shamt);
            rv_ctrl_pkg::ALU_OR:   result = rs1 | op_b;
            rv_ctrl_pkg::ALU_XOR:  result = rs1 ^ op_b;
            rv_ctrl_pkg::ALU_AND:  result = rs1 & op_b;
            rv_ctrl_pkg::ALU_EQ:   bcond  = (rs1 == op_b);
            rv_ctrl_pkg::ALU_NE:   bcond  = (rs1 != op_b);
            rv_ctrl_pkg::ALU_LT:   bcond  = lt_s;
            rv_ctrl_pkg::ALU_GE:   bcond  = !lt_s;
            rv_ctrl_pkg::ALU_LTU:  bcond  = lt_u;
            rv_ctrl_pkg::ALU_GEU:  bcond  = !lt_u;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_decoder.sv
`default_nettype none

module rv_decoder (
    input  logic                          RSTn,
    input  logic [rv_isa_pkg::XLEN-1:0]   inst,
    output logic                          I_MEM_CSN,
    output logic                          D_MEM_CSN,
    output logic                          D_MEM_WEN,
    output logic [3:0]                    D_MEM_BE,
    output logic                          RF_WE,
    output logic [4:0]                    rs1_addr,
    output logic [4:0]                    rs2_addr,
    output logic [4:0]                    rd_addr,
    output logic [rv_isa_pkg::XLEN-1:0]   imm,
    output rv_ctrl_pkg::alu_op_e          alu_op,
    output logic                          b_is_imm,
    output rv_ctrl_pkg::wd_sel_e          wd_sel,
    output rv_ctrl_pkg::mem_size_e        load_size,
    output logic                          load_unsigned,
    output logic                          branch,
    output logic                          jump,
    output logic                          jalr,
    output logic                          halt_inst
);

    logic [2:0]                  funct3;
    logic [rv_isa_pkg::XLEN-1:0] imm_i;
    logic [rv_isa_pkg::XLEN-1:0] imm_s;
    logic [rv_isa_pkg::XLEN-1:0] imm_b;
    logic [rv_isa_pkg::XLEN-1:0] imm_u;
    logic [rv_isa_pkg::XLEN-1:0] imm_j;
    rv_ctrl_pkg::alu_op_e        arith_op;
    rv_ctrl_pkg::alu_op_e        cmp_op;
    rv_ctrl_pkg::mem_size_e      mem_size;
    logic [3:0]                  mem_be;

    assign funct3    = inst[14:12];
    assign rs1_addr  = inst[19:15];
    assign rs2_addr  = inst[24:20];
    assign rd_addr   = inst[11:7];
    assign halt_inst = (inst == rv_isa_pkg::HALT_INST);

    assign imm_i = {{21{inst[31]}}, inst[30:20]};
    assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // Shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (inst[5] && inst[30]) ? rv_ctrl_pkg::ALU_SUB  // SUB only in OP
                                                      : rv_ctrl_pkg::ALU_ADD;
            3'b001:  arith_op = rv_ctrl_pkg::ALU_SLL;
            3'b010:  arith_op = rv_ctrl_pkg::ALU_SLT;
            3'b011:  arith_op = rv_ctrl_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_ctrl_pkg::ALU_XOR;
            3'b101:  arith_op = inst[30] ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            3'b110:  arith_op = rv_ctrl_pkg::ALU_OR;
            default: arith_op = rv_ctrl_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BNE:  cmp_op = rv_ctrl_pkg::ALU_NE;
            rv_isa_pkg::F3_BLT:  cmp_op = rv_ctrl_pkg::ALU_LT;
            rv_isa_pkg::F3_BGE:  cmp_op = rv_ctrl_pkg::ALU_GE;
            rv_isa_pkg::F3_BLTU: cmp_op = rv_ctrl_pkg::ALU_LTU;
            rv_isa_pkg::F3_BGEU: cmp_op = rv_ctrl_pkg::ALU_GEU;
            default:             cmp_op = rv_ctrl_pkg::ALU_EQ; // F3_BEQ
        endcase
    end

    // Lane 0 enables, no shift by address
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_B, rv_isa_pkg::F3_BU: mem_size = rv_ctrl_pkg::MEM_BYTE;
            rv_isa_pkg::F3_H, rv_isa_pkg::F3_HU: mem_size = rv_ctrl_pkg::MEM_HALF;
            rv_isa_pkg::F3_W:                    mem_size = rv_ctrl_pkg::MEM_WORD;
            default:                             mem_size = rv_ctrl_pkg::MEM_WORD;
        endcase
        case (mem_size)
            rv_ctrl_pkg::MEM_BYTE: mem_be = 4'b0001;
            rv_ctrl_pkg::MEM_HALF: mem_be = 4'b0011;
            default:               mem_be = 4'b1111;
        endcase
    end

    always_comb begin
        I_MEM_CSN     = 1'b0;
        D_MEM_CSN     = 1'b1;
        D_MEM_WEN     = 1'b1;
        D_MEM_BE      = 4'b0000;
        RF_WE         = 1'b0;
        imm           = imm_i;
        alu_op        = rv_ctrl_pkg::ALU_ADD; // Address add for loads and stores
        b_is_imm      = 1'b1;
        wd_sel        = rv_ctrl_pkg::WD_ALU;
        load_size     = rv_ctrl_pkg::MEM_WORD;
        load_unsigned = 1'b0;
        branch        = 1'b0;
        jump          = 1'b0;
        jalr          = 1'b0;

        case (rv_isa_pkg::opcode_e'(inst[6:0]))
            rv_isa_pkg::OP: begin
                RF_WE    = 1'b1;
                alu_op   = arith_op;
                b_is_imm = 1'b0;
            end
            rv_isa_pkg::OP_IMM: begin
                RF_WE  = 1'b1;
                alu_op = arith_op;
            end
            rv_isa_pkg::LOAD: begin
                D_MEM_CSN     = 1'b0;
                D_MEM_BE      = mem_be;
                RF_WE         = 1'b1;
                wd_sel        = rv_ctrl_pkg::WD_MEM;
                load_size     = mem_size;
                load_unsigned = (funct3 == rv_isa_pkg::F3_BU) || (funct3 == rv_isa_pkg::F3_HU);
            end
            rv_isa_pkg::STORE: begin
                D_MEM_CSN = 1'b0;
                D_MEM_WEN = 1'b0;
                D_MEM_BE  = mem_be;
                imm       = imm_s;
            end
            rv_isa_pkg::BRANCH: begin
                imm      = imm_b;
                alu_op   = cmp_op;
                b_is_imm = 1'b0; // Compare rs1 with rs2
                branch   = 1'b1;
            end
            rv_isa_pkg::LUI: begin
                RF_WE  = 1'b1;
                imm    = imm_u;
                wd_sel = rv_ctrl_pkg::WD_IMM;
            end
            rv_isa_pkg::AUIPC: begin
                RF_WE  = 1'b1;
                imm    = imm_u;
                wd_sel = rv_ctrl_pkg::WD_PC_IMM;
            end
            rv_isa_pkg::JAL: begin
                RF_WE  = 1'b1;
                imm    = imm_j;
                wd_sel = rv_ctrl_pkg::WD_PC4;
                jump   = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                RF_WE  = 1'b1;
                wd_sel = rv_ctrl_pkg::WD_PC4;
                jump   = 1'b1;
                jalr   = 1'b1;
            end
            default: ;
        endcase

        // Strobes idle in reset
        if (!RSTn) begin
            I_MEM_CSN = 1'b1;
            D_MEM_CSN = 1'b1;
            D_MEM_WEN = 1'b1;
            D_MEM_BE  = 4'b0000;
            RF_WE     = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    // Execution unit operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_SLL  = 4'd4,
        ALU_SRL  = 4'd5,
        ALU_SRA  = 4'd6,
        ALU_OR   = 4'd7,
        ALU_XOR  = 4'd8,
        ALU_AND  = 4'd9,
        // Compares, drive bcond only
        ALU_EQ   = 4'd10,
        ALU_NE   = 4'd11,
        ALU_LT   = 4'd12,
        ALU_GE   = 4'd13,
        ALU_LTU  = 4'd14,
        ALU_GEU  = 4'd15
    } alu_op_e;

    // Source of the register write data
    typedef enum logic [2:0] {
        WD_ALU    = 3'd0,
        WD_MEM    = 3'd1,
        WD_PC4    = 3'd2, // Link address
        WD_IMM    = 3'd3, // LUI
        WD_PC_IMM = 3'd4  // AUIPC
    } wd_sel_e;

    // Access width of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

endpackage

`default_nettype wire

//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // jalr x0, 0(x1), ends the program when x1 holds 12
    localparam logic [XLEN-1:0] HALT_INST      = 32'h0000_8067;
    localparam logic [XLEN-1:0] HALT_RS1_VALUE = 32'd12;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store widths
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100; // Loads only
    localparam logic [2:0] F3_HU = 3'b101; // Loads only

endpackage

`default_nettype wire
